/* include/dwc_cfg.svh */
// AXI upsizer configuration
// Data, address, ID and burst-length widths shared by the whole design

`ifndef DWC_CFG_SVH
`define DWC_CFG_SVH

// Narrow slave port data width in bits
`define DWC_SLV_DW 32

// Wide master port data width in bits
`define DWC_MST_DW 64

// Byte address width
`define DWC_AW 16

// Transaction ID width
`define DWC_IDW 4

// AXI burst length field width
`define DWC_LENW 8

`endif

/* hw/dwc_pkg.sv */
// AXI upsizer package
// Channel types, port structs, enums and address helpers

`include "dwc_cfg.svh"

package dwc_pkg;

  typedef logic [`DWC_AW-1:0]       addr_t;
  typedef logic [`DWC_IDW-1:0]      id_t;
  typedef logic [`DWC_LENW-1:0]     len_t;
  typedef logic [2:0]               size_t;
  typedef logic [3:0]               cache_t;
  typedef logic [1:0]               resp_t;
  typedef logic [`DWC_SLV_DW-1:0]   slv_data_t;
  typedef logic [`DWC_SLV_DW/8-1:0] slv_strb_t;
  typedef logic [`DWC_MST_DW-1:0]   mst_data_t;
  typedef logic [`DWC_MST_DW/8-1:0] mst_strb_t;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  // Upsizer state, also the start mode picked by the resize block
  typedef enum logic [1:0] {
    IDLE,
    PASSTHROUGH,
    INCR_UPSIZE
  } upsize_mode_e;

  // AW and AR share one command layout
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
    cache_t cache;
  } ax_chan_t;

  typedef struct packed {
    slv_data_t data;
    slv_strb_t strb;
    logic      last;
  } slv_w_chan_t;

  typedef struct packed {
    mst_data_t data;
    mst_strb_t strb;
    logic      last;
  } mst_w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    id_t       id;
    slv_data_t data;
    resp_t     resp;
    logic      last;
  } slv_r_chan_t;

  typedef struct packed {
    id_t       id;
    mst_data_t data;
    resp_t     resp;
    logic      last;
  } mst_r_chan_t;

  typedef struct packed {
    ax_chan_t    aw;
    logic        aw_valid;
    slv_w_chan_t w;
    logic        w_valid;
    logic        b_ready;
    ax_chan_t    ar;
    logic        ar_valid;
    logic        r_ready;
  } slv_req_t;

  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    b_chan_t     b;
    logic        b_valid;
    logic        ar_ready;
    slv_r_chan_t r;
    logic        r_valid;
  } slv_resp_t;

  typedef struct packed {
    ax_chan_t    aw;
    logic        aw_valid;
    mst_w_chan_t w;
    logic        w_valid;
    logic        b_ready;
    ax_chan_t    ar;
    logic        ar_valid;
    logic        r_ready;
  } mst_req_t;

  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    b_chan_t     b;
    logic        b_valid;
    logic        ar_ready;
    mst_r_chan_t r;
    logic        r_valid;
  } mst_resp_t;

  // Clear the address bits below the beat size
  function automatic addr_t aligned_addr(addr_t addr, size_t size);
    addr_t mask;
    mask = ~((addr_t'(1) << size) - addr_t'(1));
    return addr & mask;
  endfunction

  function automatic logic is_modifiable(cache_t cache);
    return cache[1];
  endfunction

endpackage

/* hw/dwc_burst_resize.sv */
// Burst resize decoder
// Turns a narrow AW/AR command into the wide command and its upsize mode

`timescale 1ns/1ps
`include "dwc_cfg.svh"

module dwc_burst_resize
  import dwc_pkg::*;
(
  input  ax_chan_t     cmd_i,
  output ax_chan_t     cmd_o,
  output upsize_mode_e mode_o
);

  localparam size_t MST_SIZE = size_t'($clog2(`DWC_MST_DW / 8));

  addr_t last_addr;
  addr_t start_wide;
  addr_t last_wide;
  addr_t wide_span;
  logic  upsize;

  // Address of the final narrow beat of an INCR burst
  assign last_addr = aligned_addr(cmd_i.addr, cmd_i.size) + (addr_t'(cmd_i.len) << cmd_i.size);

  assign start_wide = aligned_addr(cmd_i.addr, MST_SIZE);
  assign last_wide  = aligned_addr(last_addr, MST_SIZE);
  assign wide_span  = (last_wide - start_wide) >> MST_SIZE;

  // Only modifiable multi-beat INCR bursts may be packed
  assign upsize = (cmd_i.burst == INCR) && is_modifiable(cmd_i.cache) && (cmd_i.len != '0);

  always_comb begin
    cmd_o  = cmd_i;
    mode_o = PASSTHROUGH;
    if (upsize) begin
      cmd_o.len  = len_t'(wide_span);
      cmd_o.size = MST_SIZE;
      mode_o     = INCR_UPSIZE;
    end
  end

endmodule

/* hw/dwc_write_upsizer.sv */
// Write path of the AXI upsizer
// Forwards AW, packs narrow W beats into wide beats, passes B straight back

`timescale 1ns/1ps
`include "dwc_cfg.svh"

module dwc_write_upsizer
  import dwc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  ax_chan_t    aw_i,
  input  logic        aw_valid_i,
  output logic        aw_ready_o,
  input  slv_w_chan_t w_i,
  input  logic        w_valid_i,
  output logic        w_ready_o,
  output ax_chan_t    mst_aw_o,
  output logic        mst_aw_valid_o,
  input  logic        mst_aw_ready_i,
  output mst_w_chan_t mst_w_o,
  output logic        mst_w_valid_o,
  input  logic        mst_w_ready_i,
  input  b_chan_t     mst_b_i,
  input  logic        mst_b_valid_i,
  output logic        mst_b_ready_o,
  output b_chan_t     b_o,
  output logic        b_valid_o,
  input  logic        b_ready_i
);

  localparam int unsigned SLV_BYTES = `DWC_SLV_DW / 8;
  localparam int unsigned MST_BYTES = `DWC_MST_DW / 8;
  localparam size_t       MST_SIZE  = size_t'($clog2(MST_BYTES));

  upsize_mode_e state_q, state_d;
  ax_chan_t     aw_q, aw_d;
  logic         aw_valid_q, aw_valid_d;
  mst_w_chan_t  w_q, w_d;
  logic         w_valid_q, w_valid_d;
  addr_t        addr_q, addr_d;
  len_t         cnt_q, cnt_d;
  size_t        size_q, size_d;
  logic         done_q, done_d;

  ax_chan_t     wide_aw;
  upsize_mode_e start_mode;

  dwc_burst_resize u_aw_resize (
    .cmd_i  (aw_i),
    .cmd_o  (wide_aw),
    .mode_o (start_mode)
  );

  assign aw_ready_o     = (state_q == IDLE);
  assign mst_aw_o       = aw_q;
  assign mst_aw_valid_o = aw_valid_q;
  assign mst_w_o        = w_q;
  assign mst_w_valid_o  = w_valid_q;

  // Narrow beats wait for the wide AW, and stop after the last one
  assign w_ready_o = (state_q != IDLE) && !aw_valid_q && !done_q &&
                     (!w_valid_q || mst_w_ready_i);

  assign b_o           = mst_b_i;
  assign b_valid_o     = mst_b_valid_i;
  assign mst_b_ready_o = b_ready_i;

  always_comb begin
    int unsigned mst_off;
    int unsigned beat_bytes;

    state_d    = state_q;
    aw_d       = aw_q;
    aw_valid_d = aw_valid_q;
    w_d        = w_q;
    w_valid_d  = w_valid_q;
    addr_d     = addr_q;
    cnt_d      = cnt_q;
    size_d     = size_q;
    done_d     = done_q;
    mst_off    = int'(addr_q[MST_SIZE-1:0]);
    beat_bytes = 1 << size_q;

    if (aw_valid_i && aw_ready_o) begin
      state_d    = start_mode;
      aw_d       = wide_aw;
      aw_valid_d = 1'b1;
      addr_d     = aw_i.addr;
      cnt_d      = aw_i.len;
      size_d     = aw_i.size;
      done_d     = 1'b0;
    end

    if (mst_aw_valid_o && mst_aw_ready_i) begin
      aw_valid_d = 1'b0;
    end

    // Wide beat taken, start a fresh one
    if (mst_w_valid_o && mst_w_ready_i) begin
      w_d       = '0;
      w_valid_d = 1'b0;
      if (w_q.last) begin
        state_d = IDLE;
      end
    end

    if (w_valid_i && w_ready_o) begin
      // Steer the narrow lanes onto the wide lanes of this address
      for (int b = 0; b < MST_BYTES; b++) begin
        if ((b >= mst_off) && (b < mst_off + beat_bytes) &&
            ((b / SLV_BYTES) == (mst_off / SLV_BYTES))) begin
          w_d.data[8*b +: 8] = w_i.data[8*(b % SLV_BYTES) +: 8];
          w_d.strb[b]        = w_i.strb[b % SLV_BYTES];
        end
      end
      w_d.last = (cnt_q == '0);
      cnt_d    = cnt_q - 1'b1;
      done_d   = (cnt_q == '0);

      if (aw_q.burst != FIXED) begin
        addr_d = aligned_addr(addr_q, size_q) + (addr_t'(1) << size_q);
      end

      // Release on every beat, or once the wide word is full
      if ((state_q == PASSTHROUGH) || (cnt_q == '0) ||
          (aligned_addr(addr_d, MST_SIZE) != aligned_addr(addr_q, MST_SIZE))) begin
        w_valid_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      aw_valid_q <= 1'b0;
      w_q        <= '0;
      w_valid_q  <= 1'b0;
      addr_q     <= '0;
      cnt_q      <= '0;
      done_q     <= 1'b0;
    end else begin
      state_q    <= state_d;
      aw_valid_q <= aw_valid_d;
      w_q        <= w_d;
      w_valid_q  <= w_valid_d;
      addr_q     <= addr_d;
      cnt_q      <= cnt_d;
      done_q     <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    aw_q   <= aw_d;
    size_q <= size_d;
  end

endmodule

/* hw/dwc_read_upsizer.sv */
// Read path of the AXI upsizer
// Forwards AR and splits each wide R beat into the narrow beats it holds

`timescale 1ns/1ps
`include "dwc_cfg.svh"

module dwc_read_upsizer
  import dwc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  ax_chan_t    ar_i,
  input  logic        ar_valid_i,
  output logic        ar_ready_o,
  output ax_chan_t    mst_ar_o,
  output logic        mst_ar_valid_o,
  input  logic        mst_ar_ready_i,
  input  mst_r_chan_t mst_r_i,
  input  logic        mst_r_valid_i,
  output logic        mst_r_ready_o,
  output slv_r_chan_t r_o,
  output logic        r_valid_o,
  input  logic        r_ready_i
);

  localparam int unsigned SLV_BYTES = `DWC_SLV_DW / 8;
  localparam int unsigned MST_BYTES = `DWC_MST_DW / 8;
  localparam size_t       MST_SIZE  = size_t'($clog2(MST_BYTES));

  upsize_mode_e state_q, state_d;
  ax_chan_t     ar_q, ar_d;
  logic         ar_valid_q, ar_valid_d;
  addr_t        addr_q, addr_d;
  len_t         cnt_q, cnt_d;
  size_t        size_q, size_d;

  ax_chan_t     wide_ar;
  upsize_mode_e start_mode;

  dwc_burst_resize u_ar_resize (
    .cmd_i  (ar_i),
    .cmd_o  (wide_ar),
    .mode_o (start_mode)
  );

  assign ar_ready_o     = (state_q == IDLE);
  assign mst_ar_o       = ar_q;
  assign mst_ar_valid_o = ar_valid_q;

  // R only flows once the wide AR has gone out
  assign r_valid_o = (state_q != IDLE) && !ar_valid_q && mst_r_valid_i;

  always_comb begin
    int unsigned mst_off;
    int unsigned beat_bytes;

    state_d       = state_q;
    ar_d          = ar_q;
    ar_valid_d    = ar_valid_q;
    addr_d        = addr_q;
    cnt_d         = cnt_q;
    size_d        = size_q;
    mst_r_ready_o = 1'b0;
    mst_off       = int'(addr_q[MST_SIZE-1:0]);
    beat_bytes    = 1 << size_q;

    r_o      = '0;
    r_o.id   = mst_r_i.id;
    r_o.resp = mst_r_i.resp;
    r_o.last = mst_r_i.last && (cnt_q == '0);

    // Pick the bytes of this narrow beat out of the wide word
    for (int b = 0; b < MST_BYTES; b++) begin
      if ((b >= mst_off) && (b < mst_off + beat_bytes) &&
          ((b / SLV_BYTES) == (mst_off / SLV_BYTES))) begin
        r_o.data[8*(b % SLV_BYTES) +: 8] = mst_r_i.data[8*b +: 8];
      end
    end

    if (ar_valid_i && ar_ready_o) begin
      state_d    = start_mode;
      ar_d       = wide_ar;
      ar_valid_d = 1'b1;
      addr_d     = ar_i.addr;
      cnt_d      = ar_i.len;
      size_d     = ar_i.size;
    end

    if (mst_ar_valid_o && mst_ar_ready_i) begin
      ar_valid_d = 1'b0;
    end

    if (r_valid_o && r_ready_i) begin
      cnt_d = cnt_q - 1'b1;
      if (ar_q.burst != FIXED) begin
        addr_d = aligned_addr(addr_q, size_q) + (addr_t'(1) << size_q);
      end

      // Keep the wide beat until its last narrow lane is used
      if ((state_q == PASSTHROUGH) || (cnt_q == '0) ||
          (aligned_addr(addr_d, MST_SIZE) != aligned_addr(addr_q, MST_SIZE))) begin
        mst_r_ready_o = 1'b1;
      end

      if (cnt_q == '0) begin
        state_d = IDLE;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      ar_valid_q <= 1'b0;
      addr_q     <= '0;
      cnt_q      <= '0;
    end else begin
      state_q    <= state_d;
      ar_valid_q <= ar_valid_d;
      addr_q     <= addr_d;
      cnt_q      <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ar_q   <= ar_d;
    size_q <= size_d;
  end

endmodule

/* hw/dwc_upsizer.sv */
// AXI data-width upsizer, 32-bit slave port to 64-bit master port
// Splits both ports between the write and the read upsizer

`timescale 1ns/1ps

module dwc_upsizer
  import dwc_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  slv_req_t  slv_req_i,
  output slv_resp_t slv_resp_o,
  output mst_req_t  mst_req_o,
  input  mst_resp_t mst_resp_i
);

  // AW, W and B
  dwc_write_upsizer u_write (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .aw_i           (slv_req_i.aw),
    .aw_valid_i     (slv_req_i.aw_valid),
    .aw_ready_o     (slv_resp_o.aw_ready),
    .w_i            (slv_req_i.w),
    .w_valid_i      (slv_req_i.w_valid),
    .w_ready_o      (slv_resp_o.w_ready),
    .mst_aw_o       (mst_req_o.aw),
    .mst_aw_valid_o (mst_req_o.aw_valid),
    .mst_aw_ready_i (mst_resp_i.aw_ready),
    .mst_w_o        (mst_req_o.w),
    .mst_w_valid_o  (mst_req_o.w_valid),
    .mst_w_ready_i  (mst_resp_i.w_ready),
    .mst_b_i        (mst_resp_i.b),
    .mst_b_valid_i  (mst_resp_i.b_valid),
    .mst_b_ready_o  (mst_req_o.b_ready),
    .b_o            (slv_resp_o.b),
    .b_valid_o      (slv_resp_o.b_valid),
    .b_ready_i      (slv_req_i.b_ready)
  );

  // AR and R
  dwc_read_upsizer u_read (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ar_i           (slv_req_i.ar),
    .ar_valid_i     (slv_req_i.ar_valid),
    .ar_ready_o     (slv_resp_o.ar_ready),
    .mst_ar_o       (mst_req_o.ar),
    .mst_ar_valid_o (mst_req_o.ar_valid),
    .mst_ar_ready_i (mst_resp_i.ar_ready),
    .mst_r_i        (mst_resp_i.r),
    .mst_r_valid_i  (mst_resp_i.r_valid),
    .mst_r_ready_o  (mst_req_o.r_ready),
    .r_o            (slv_resp_o.r),
    .r_valid_o      (slv_resp_o.r_valid),
    .r_ready_i      (slv_req_i.r_ready)
  );

endmodule

/* tb/tb_axi_mem.sv */
// Behavioral 64-bit AXI memory slave
// One write and one read burst at a time, random ready back-pressure

`timescale 1ns/1ps
`include "dwc_cfg.svh"

module tb_axi_mem
  import dwc_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  mst_req_t  req_i,
  output mst_resp_t resp_o
);

  logic [7:0]  mem [0:(1<<`DWC_AW)-1];
  logic [31:0] rnd_q;
  logic        w_act_q, b_pend_q, r_act_q;
  addr_t       waddr_q, raddr_q;
  size_t       wsize_q, rsize_q;
  burst_e      wburst_q, rburst_q;
  id_t         wid_q, rid_q;
  len_t        rcnt_q;
  logic        aw_hs, w_hs, b_hs, ar_hs, r_hs;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Address of the following beat
  function automatic addr_t next_beat(input addr_t a, input size_t s, input burst_e burst);
    addr_t step;
    step = addr_t'(1) << s;
    if (burst == FIXED) begin
      return a;
    end
    return (a & ~(step - addr_t'(1))) + step;
  endfunction

  // Fill pattern built from both address bytes
  initial begin
    for (int a = 0; a < (1 << `DWC_AW); a++) begin
      mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
    end
  end

  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = rnd_q[16] && !w_act_q && !b_pend_q;
    resp_o.w_ready  = rnd_q[17] && w_act_q;
    resp_o.b_valid  = b_pend_q;
    resp_o.b.id     = wid_q;
    resp_o.b.resp   = 2'b00;
    resp_o.ar_ready = rnd_q[18] && !r_act_q;
    resp_o.r_valid  = r_act_q;
    resp_o.r.id     = rid_q;
    resp_o.r.resp   = 2'b00;
    resp_o.r.last   = (rcnt_q == '0);
    for (int b = 0; b < 8; b++) begin
      resp_o.r.data[8*b +: 8] = mem[{raddr_q[`DWC_AW-1:3], 3'b000} + addr_t'(b)];
    end
  end

  assign aw_hs = req_i.aw_valid && resp_o.aw_ready;
  assign w_hs  = req_i.w_valid && resp_o.w_ready;
  assign b_hs  = resp_o.b_valid && req_i.b_ready;
  assign ar_hs = req_i.ar_valid && resp_o.ar_ready;
  assign r_hs  = resp_o.r_valid && req_i.r_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rnd_q    <= 32'd74034;
      w_act_q  <= 1'b0;
      b_pend_q <= 1'b0;
      r_act_q  <= 1'b0;
      waddr_q  <= '0;
      raddr_q  <= '0;
      wsize_q  <= '0;
      rsize_q  <= '0;
      wburst_q <= INCR;
      rburst_q <= INCR;
      wid_q    <= '0;
      rid_q    <= '0;
      rcnt_q   <= '0;
    end else begin
      rnd_q <= lcg_next(rnd_q);
      if (aw_hs) begin
        w_act_q  <= 1'b1;
        waddr_q  <= req_i.aw.addr;
        wsize_q  <= req_i.aw.size;
        wburst_q <= req_i.aw.burst;
        wid_q    <= req_i.aw.id;
      end
      if (w_hs) begin
        waddr_q <= next_beat(waddr_q, wsize_q, wburst_q);
        if (req_i.w.last) begin
          w_act_q  <= 1'b0;
          b_pend_q <= 1'b1;
        end
      end
      if (b_hs) begin
        b_pend_q <= 1'b0;
      end
      if (ar_hs) begin
        r_act_q  <= 1'b1;
        raddr_q  <= req_i.ar.addr;
        rsize_q  <= req_i.ar.size;
        rburst_q <= req_i.ar.burst;
        rid_q    <= req_i.ar.id;
        rcnt_q   <= req_i.ar.len;
      end
      if (r_hs) begin
        raddr_q <= next_beat(raddr_q, rsize_q, rburst_q);
        rcnt_q  <= rcnt_q - len_t'(1);
        if (rcnt_q == '0) begin
          r_act_q <= 1'b0;
        end
      end
    end
  end

  // Strobed byte writes into the wide word
  always_ff @(posedge clk_i) begin
    if (w_hs) begin
      for (int b = 0; b < 8; b++) begin
        if (req_i.w.strb[b]) begin
          mem[{waddr_q[`DWC_AW-1:3], 3'b000} + addr_t'(b)] <= req_i.w.data[8*b +: 8];
        end
      end
    end
  end

endmodule

/* tb/tb_dwc_upsizer.sv */
// Testbench for the AXI data-width upsizer
// Random write and read-back bursts against a behavioral wide memory

`timescale 1ns/1ps
`include "dwc_cfg.svh"

module tb_dwc_upsizer;
  import dwc_pkg::*;

  localparam int TIMEOUT   = 2000;
  localparam int NUM_TESTS = 60;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  slv_req_t    slv_req;
  slv_resp_t   slv_resp;
  mst_req_t    mst_req;
  mst_resp_t   mst_resp;

  ax_chan_t    aw_cmd, ar_cmd;
  slv_w_chan_t w_beat;
  logic        aw_valid, w_valid, ar_valid, b_ready, r_ready;

  logic [7:0]  mirror [0:(1<<`DWC_AW)-1];
  logic [31:0] stim_rng = 32'd74034;
  logic [31:0] rdy_rng  = 32'd74034 ^ 32'hffff;
  int          writes_sent, b_seen, mst_w_beats;
  len_t        exp_mst_len;
  size_t       exp_mst_size;
  ax_chan_t    exp_cmd;
  logic [31:0] exp_rdata_q [$];
  logic        exp_rlast_q [$];

  always #2 clk_i = ~clk_i;

  dwc_upsizer u_dwc_upsizer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp),
    .mst_req_o  (mst_req),
    .mst_resp_i (mst_resp)
  );

  tb_axi_mem u_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (mst_req),
    .resp_o (mst_resp)
  );

  always_comb begin
    slv_req          = '0;
    slv_req.aw       = aw_cmd;
    slv_req.aw_valid = aw_valid;
    slv_req.w        = w_beat;
    slv_req.w_valid  = w_valid;
    slv_req.b_ready  = b_ready;
    slv_req.ar       = ar_cmd;
    slv_req.ar_valid = ar_valid;
    slv_req.r_ready  = r_ready;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int rand_below(input int n);
    stim_rng = lcg_next(stim_rng);
    return int'(stim_rng[23:8]) % n;
  endfunction

  // Expected wide len from the span of wide words the burst touches
  function automatic len_t ref_mst_len(input ax_chan_t c);
    logic [31:0] last_beat;
    if (c.burst != INCR || !c.cache[1] || c.len == '0) begin
      return c.len;
    end
    last_beat = 32'(c.addr) + (32'(c.len) << c.size);
    return len_t'((last_beat >> 3) - (32'(c.addr) >> 3));
  endfunction

  function automatic size_t ref_mst_size(input ax_chan_t c);
    if (c.burst != INCR || !c.cache[1] || c.len == '0) begin
      return c.size;
    end
    return size_t'(3);
  endfunction

  // Narrow read data with mirror bytes on lanes a mod 4 upward and zero elsewhere
  function automatic logic [31:0] ref_rdata(input int a, input int nb);
    logic [31:0] d;
    d = '0;
    for (int k = 0; k < nb; k++) begin
      d[8*((a % 4) + k) +: 8] = mirror[a + k];
    end
    return d;
  endfunction

  function automatic int beat_addr(input ax_chan_t c, input int i);
    if (c.burst == FIXED) begin
      return int'(c.addr);
    end
    return int'(c.addr) + (i << c.size);
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, msg);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
               $time, name, got, exp);
      fail_run("value mismatch");
    end
  endtask

  // Wide AW or AR against the narrow command with the R1 len and size
  task automatic check_cmd(input string chan, input ax_chan_t got);
    check_value({chan, ".id"}, 64'(got.id), 64'(exp_cmd.id));
    check_value({chan, ".addr"}, 64'(got.addr), 64'(exp_cmd.addr));
    check_value({chan, ".len"}, 64'(got.len), 64'(exp_mst_len));
    check_value({chan, ".size"}, 64'(got.size), 64'(exp_mst_size));
    check_value({chan, ".burst"}, 64'(got.burst), 64'(exp_cmd.burst));
    check_value({chan, ".cache"}, 64'(got.cache), 64'(exp_cmd.cache));
  endtask

  // Narrow-side response readiness
  always @(negedge clk_i) begin
    rdy_rng = lcg_next(rdy_rng);
    b_ready = rdy_rng[20];
    r_ready = rdy_rng[22];
  end

  // Monitor samples one ns before each rising edge
  always begin
    @(negedge clk_i);
    #1;
    if (rst_ni) begin
      if (mst_req.aw_valid && mst_resp.aw_ready) begin
        check_cmd("mst_req_o.aw", mst_req.aw);
      end
      if (mst_req.ar_valid && mst_resp.ar_ready) begin
        check_cmd("mst_req_o.ar", mst_req.ar);
      end
      if (mst_req.w_valid && mst_resp.w_ready) begin
        mst_w_beats++;
      end
      if (slv_resp.b_valid && b_ready) begin
        check_value("slv_resp_o.b.id", 64'(slv_resp.b.id), 64'(exp_cmd.id));
        check_value("slv_resp_o.b.resp", 64'(slv_resp.b.resp), 64'(0));
        check_value("mst w beat count", 64'(mst_w_beats), 64'(exp_mst_len) + 64'(1));
        mst_w_beats = 0;
        b_seen++;
      end
      if (slv_resp.r_valid && r_ready) begin
        if (exp_rdata_q.size() == 0) begin
          fail_run("narrow R beat arrived with no read outstanding");
        end
        check_value("slv_resp_o.r.data", 64'(slv_resp.r.data), 64'(exp_rdata_q.pop_front()));
        check_value("slv_resp_o.r.last", 64'(slv_resp.r.last), 64'(exp_rlast_q.pop_front()));
        check_value("slv_resp_o.r.id", 64'(slv_resp.r.id), 64'(exp_cmd.id));
      end
    end
  end

  // Each send task starts and ends on a falling edge
  task automatic send_aw(input ax_chan_t c);
    int t;
    aw_cmd   = c;
    aw_valid = 1'b1;
    t = 0;
    forever begin
      #1;
      if (slv_resp.aw_ready) break;
      t++;
      if (t > TIMEOUT) fail_run("timeout waiting for AW ready");
      @(negedge clk_i);
    end
    @(negedge clk_i);
    aw_valid = 1'b0;
  endtask

  task automatic send_w(input slv_w_chan_t beat);
    int t;
    w_beat  = beat;
    w_valid = 1'b1;
    t = 0;
    forever begin
      #1;
      if (slv_resp.w_ready) break;
      t++;
      if (t > TIMEOUT) fail_run("timeout waiting for W ready");
      @(negedge clk_i);
    end
    @(negedge clk_i);
    w_valid = 1'b0;
  endtask

  task automatic send_ar(input ax_chan_t c);
    int t;
    ar_cmd   = c;
    ar_valid = 1'b1;
    t = 0;
    forever begin
      #1;
      if (slv_resp.ar_ready) break;
      t++;
      if (t > TIMEOUT) fail_run("timeout waiting for AR ready");
      @(negedge clk_i);
    end
    @(negedge clk_i);
    ar_valid = 1'b0;
  endtask

  task automatic do_write(input ax_chan_t c);
    slv_w_chan_t beat;
    int          a, nb, t;
    nb           = 1 << c.size;
    exp_mst_len  = ref_mst_len(c);
    exp_mst_size = ref_mst_size(c);
    exp_cmd      = c;
    writes_sent++;
    send_aw(c);
    for (int i = 0; i <= int'(c.len); i++) begin
      a = beat_addr(c, i);
      stim_rng = lcg_next(stim_rng);
      beat.data = stim_rng;
      beat.strb = '0;
      beat.last = (i == int'(c.len));
      for (int k = 0; k < nb; k++) begin
        beat.strb[(a % 4) + k] = 1'b1;
        mirror[a + k] = beat.data[8*((a % 4) + k) +: 8];
      end
      send_w(beat);
    end
    t = 0;
    while (b_seen != writes_sent) begin
      t++;
      if (t > TIMEOUT) fail_run("timeout waiting for the B response");
      @(negedge clk_i);
    end
  endtask

  task automatic do_read(input ax_chan_t c);
    int t;
    exp_mst_len  = ref_mst_len(c);
    exp_mst_size = ref_mst_size(c);
    exp_cmd      = c;
    for (int i = 0; i <= int'(c.len); i++) begin
      exp_rdata_q.push_back(ref_rdata(beat_addr(c, i), 1 << c.size));
      exp_rlast_q.push_back(i == int'(c.len));
    end
    send_ar(c);
    t = 0;
    while (exp_rdata_q.size() != 0) begin
      t++;
      if (t > TIMEOUT) fail_run("timeout waiting for the read data");
      @(negedge clk_i);
    end
  endtask

  task automatic run_burst(input int addr, input int len, input int size,
                           input burst_e burst, input logic [3:0] cache);
    ax_chan_t c;
    c       = '0;
    c.id    = id_t'(rand_below(16));
    c.addr  = addr_t'(addr & ~((1 << size) - 1));
    c.len   = len_t'(len);
    c.size  = size_t'(size);
    c.burst = burst;
    c.cache = cache;
    do_write(c);
    do_read(c);
  endtask

  initial begin
    rst_ni   = 1'b0;
    aw_cmd   = '0;
    w_beat   = '0;
    ar_cmd   = '0;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    ar_valid = 1'b0;
    b_ready  = 1'b0;
    r_ready  = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_value("mst_req_o.aw_valid", 64'(mst_req.aw_valid), 64'(0));
    check_value("mst_req_o.w_valid", 64'(mst_req.w_valid), 64'(0));
    check_value("mst_req_o.ar_valid", 64'(mst_req.ar_valid), 64'(0));
    check_value("mst_req_o.r_ready", 64'(mst_req.r_ready), 64'(0));
    check_value("slv_resp_o.w_ready", 64'(slv_resp.w_ready), 64'(0));
    check_value("slv_resp_o.aw_ready", 64'(slv_resp.aw_ready), 64'(1));
    check_value("slv_resp_o.ar_ready", 64'(slv_resp.ar_ready), 64'(1));
    @(negedge clk_i);

    // Directed packed INCR, FIXED, non-modifiable and single-beat cases
    run_burst(32'h0104, 7, 2, INCR, 4'b0010);
    run_burst(32'h0203, 9, 0, INCR, 4'b0011);
    run_burst(32'h0300, 3, 2, FIXED, 4'b0010);
    run_burst(32'h0402, 5, 1, INCR, 4'b0000);
    run_burst(32'h0506, 0, 1, INCR, 4'b0010);

    for (int n = 0; n < NUM_TESTS; n++) begin
      run_burst(rand_below(32'h4000), rand_below(16), rand_below(3),
                (rand_below(4) == 0) ? FIXED : INCR,
                (rand_below(4) == 0) ? 4'b0000 : 4'b0010);
    end

    if (b_seen == writes_sent && exp_rdata_q.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      fail_run("transactions still outstanding at the end of the run");
    end
  end

endmodule

/* src.f */
+incdir+include
hw/dwc_pkg.sv
hw/dwc_burst_resize.sv
hw/dwc_write_upsizer.sv
hw/dwc_read_upsizer.sv
hw/dwc_upsizer.sv
tb/tb_axi_mem.sv
tb/tb_dwc_upsizer.sv

/* Makefile */
# Verilator build for the AXI upsizer testbench

VERILATOR ?= verilator
TOP       ?= tb_dwc_upsizer
BUILD_DIR ?= build
VFLAGS    ?= --binary -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, exit status gives pass or fail"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f src.f
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
